// File: mau_pkg.sv
// Shared widths and types for the L1 memory access unit
// Byte addresses are 32 bits and the Wishbone data path is one 32-bit word
// The beat index is 4 bits, so a line holds at most 16 words
package mau_pkg;

	parameter int MAU_ADDR_WIDTH = 32;
	parameter int MAU_DATA_WIDTH = 32;
	parameter int MAU_BE_WIDTH   = 4;
	parameter int MAU_CNT_WIDTH  = 4;

	// Which cache port a request came from
	typedef enum logic {
		SRC_I = 1'b0,
		SRC_D = 1'b1
	} mau_src_e;

	// Issue side states
	typedef enum logic {
		ISSUE_IDLE  = 1'b0,
		ISSUE_BURST = 1'b1
	} mau_issue_state_e;

	// One outstanding request as seen by the ack side
	typedef struct packed {
		mau_src_e                 src;
		logic                     we;
		logic                     nc;
		// Zero for writes and uncached reads
		logic [MAU_CNT_WIDTH-1:0] last_idx;
	} mau_tag_t;

endpackage

// File: mau_if.sv
// Internal interfaces of the memory access unit
// mau_tag_if carries request tags from the issue side to the ack side
// mau_cnt_if connects a beat counter to the module that steers it
`timescale 1ns/1ns

interface mau_tag_if;

	logic                push;
	mau_pkg::mau_tag_t   push_tag;
	logic                full;
	logic                pop;
	mau_pkg::mau_tag_t   pop_tag;
	logic                empty;

	modport issue   (output push, output push_tag, input full);
	modport queue   (input push, input push_tag, input pop,
	                 output full, output pop_tag, output empty);
	modport collect (output pop, input pop_tag, input empty);

endinterface

interface mau_cnt_if;

	logic                               load;
	logic [mau_pkg::MAU_CNT_WIDTH-1:0]  limit;
	logic                               step;
	logic [mau_pkg::MAU_CNT_WIDTH-1:0]  idx;
	logic                               last;

	modport ctrl (output load, output limit, output step, input idx, input last);
	modport cnt  (input load, input limit, input step, output idx, output last);

endinterface

// File: mau_beat_counter.sv
// Beat counter with a loadable limit
// A step in the load cycle counts the beat taken in that same cycle
// The controller must never step once the index has reached the limit
`timescale 1ns/1ns

module mau_beat_counter (
	input  logic  wb_clk_i,
	input  logic  rst_n,
	mau_cnt_if.cnt cnt
);

	localparam int W = mau_pkg::MAU_CNT_WIDTH;

	logic [W-1:0] idx_q;
	logic [W-1:0] limit_q;

	always_ff @(posedge wb_clk_i or negedge rst_n) begin
		if (!rst_n) begin
			idx_q   <= '0;
			limit_q <= '0;
		end else if (cnt.load) begin
			limit_q <= cnt.limit;
			idx_q   <= {{(W-1){1'b0}}, cnt.step};
		end else if (cnt.step) begin
			idx_q <= idx_q + 1'b1;
		end
	end

	assign cnt.idx  = idx_q;
	assign cnt.last = (idx_q == limit_q);

	// Controller keeps the count inside the loaded limit
	a_no_overstep: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
		cnt.step |-> (cnt.load ? (cnt.limit != '0) : !cnt.last));

endmodule

// File: mau_tag_queue.sv
// Circular FIFO of outstanding request tags
// The head tag is visible on pop_tag whenever the queue is not empty
// A push while full is not guarded here, the issue side must check full
`timescale 1ns/1ns

module mau_tag_queue #(
	parameter int TAG_DEPTH = 2
) (
	input  logic     wb_clk_i,
	input  logic     rst_n,
	mau_tag_if.queue q
);

	localparam int PTR_W = (TAG_DEPTH > 1) ? $clog2(TAG_DEPTH) : 1;
	localparam int CNT_W = $clog2(TAG_DEPTH + 1);

	mau_pkg::mau_tag_t mem_q [TAG_DEPTH];
	logic [PTR_W-1:0]  wr_ptr_q;
	logic [PTR_W-1:0]  rd_ptr_q;
	logic [CNT_W-1:0]  count_q;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(TAG_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge wb_clk_i) begin
		if (q.push)
			mem_q[wr_ptr_q] <= q.push_tag;
	end

	always_ff @(posedge wb_clk_i or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (q.push)
				wr_ptr_q <= ptr_inc(wr_ptr_q);
			if (q.pop)
				rd_ptr_q <= ptr_inc(rd_ptr_q);
			case ({q.push, q.pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	assign q.full    = (count_q == CNT_W'(TAG_DEPTH));
	assign q.empty   = (count_q == '0);
	assign q.pop_tag = mem_q[rd_ptr_q];

	a_no_push_full: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
		q.push |-> !q.full);

	a_no_pop_empty: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
		q.pop |-> !q.empty);

endmodule

// File: mau_issue_fsm.sv
// Request arbiter and Wishbone B4 pipelined master, issue side only
// The data port wins over the instruction port when both are pending
// Cached reads must be line aligned, the address just steps one word per beat
// wb_cyc_o stays high until the port ack of the last outstanding request,
// one cycle past its final wb_ack_i
`timescale 1ns/1ns

module mau_issue_fsm #(
	parameter int LINE_WORDS = 4
) (
	input  logic                                wb_clk_i,
	input  logic                                rst_n,
	input  logic                                l1i_req_val_i,
	input  logic [mau_pkg::MAU_ADDR_WIDTH-1:0]  l1i_req_addr_i,
	input  logic                                l1d_req_val_i,
	input  logic                                l1d_req_nc_i,
	input  logic                                l1d_req_we_i,
	input  logic [mau_pkg::MAU_ADDR_WIDTH-1:0]  l1d_req_addr_i,
	input  logic [mau_pkg::MAU_DATA_WIDTH-1:0]  l1d_req_wdata_i,
	input  logic [mau_pkg::MAU_BE_WIDTH-1:0]    l1d_req_be_i,
	input  logic                                l1i_req_ack_i,
	input  logic                                l1d_req_ack_i,
	input  logic                                wb_stall_i,
	output logic [mau_pkg::MAU_ADDR_WIDTH-1:0]  wb_adr_o,
	output logic [mau_pkg::MAU_DATA_WIDTH-1:0]  wb_dat_o,
	output logic [mau_pkg::MAU_BE_WIDTH-1:0]    wb_sel_o,
	output logic                                wb_we_o,
	output logic                                wb_stb_o,
	output logic                                wb_cyc_o,
	mau_tag_if.issue                            tag,
	mau_cnt_if.ctrl                             cnt
);

	mau_pkg::mau_issue_state_e state_q;
	mau_pkg::mau_issue_state_e state_d;

	logic sent_i_q;
	logic sent_d_q;
	logic sent_i_d;
	logic sent_d_d;
	logic acc_i;
	logic acc_d;
	logic accept;
	logic d_single;
	logic beat_acc;

	// ------------------------------
	// Arbitration
	// ------------------------------

	assign acc_d  = (state_q == mau_pkg::ISSUE_IDLE) & l1d_req_val_i & ~sent_d_q & ~tag.full;
	assign acc_i  = (state_q == mau_pkg::ISSUE_IDLE) & l1i_req_val_i & ~sent_i_q & ~tag.full
	                & ~acc_d;
	assign accept = acc_d | acc_i;

	// Writes and uncached reads move one word
	assign d_single = l1d_req_we_i | l1d_req_nc_i;

	always_comb begin
		tag.push_tag.src      = acc_d ? mau_pkg::SRC_D : mau_pkg::SRC_I;
		tag.push_tag.we       = acc_d & l1d_req_we_i;
		tag.push_tag.nc       = acc_d & l1d_req_nc_i;
		tag.push_tag.last_idx = (acc_d & d_single) ? '0
		                        : mau_pkg::MAU_CNT_WIDTH'(LINE_WORDS - 1);
	end

	assign tag.push   = accept;
	assign cnt.load   = accept;
	assign cnt.limit  = tag.push_tag.last_idx;

	// A port stays busy from acceptance until its own ack
	assign sent_d_d = acc_d | (sent_d_q & ~l1d_req_ack_i);
	assign sent_i_d = acc_i | (sent_i_q & ~l1i_req_ack_i);

	// ------------------------------
	// Burst control
	// ------------------------------

	assign beat_acc = (state_q == mau_pkg::ISSUE_BURST) & ~wb_stall_i;
	assign cnt.step = beat_acc & ~cnt.last;

	always_comb begin
		state_d = state_q;
		case (state_q)
			mau_pkg::ISSUE_IDLE:
				if (accept)
					state_d = mau_pkg::ISSUE_BURST;
			mau_pkg::ISSUE_BURST:
				if (beat_acc && cnt.last)
					state_d = mau_pkg::ISSUE_IDLE;
			default:
				state_d = mau_pkg::ISSUE_IDLE;
		endcase
	end

	always_ff @(posedge wb_clk_i or negedge rst_n) begin
		if (!rst_n) begin
			state_q  <= mau_pkg::ISSUE_IDLE;
			sent_i_q <= 1'b0;
			sent_d_q <= 1'b0;
			wb_stb_o <= 1'b0;
			wb_cyc_o <= 1'b0;
			wb_we_o  <= 1'b0;
		end else begin
			state_q  <= state_d;
			sent_i_q <= sent_i_d;
			sent_d_q <= sent_d_d;
			wb_stb_o <= (state_d == mau_pkg::ISSUE_BURST);
			wb_cyc_o <= (state_d == mau_pkg::ISSUE_BURST) | sent_i_d | sent_d_d;
			if (accept)
				wb_we_o <= acc_d & l1d_req_we_i;
		end
	end

	// Beat payload, held while stalled
	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			wb_adr_o <= acc_d ? l1d_req_addr_i : l1i_req_addr_i;
			wb_dat_o <= l1d_req_wdata_i;
			wb_sel_o <= (acc_d & d_single) ? l1d_req_be_i : '1;
		end else if (cnt.step) begin
			wb_adr_o <= wb_adr_o + mau_pkg::MAU_ADDR_WIDTH'(mau_pkg::MAU_DATA_WIDTH / 8);
		end
	end

	// A port ack always closes a request this side accepted
	a_ack_i_sent: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
		l1i_req_ack_i |-> sent_i_q);

	a_ack_d_sent: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
		l1d_req_ack_i |-> sent_d_q);

endmodule

// File: mau_line_assembler.sv
// Ack side of the memory access unit
// Acked words are gathered into one line register per port
// Each wb_ack_i belongs to the tag at the head of the queue, acks come in order
// Port data holds until the next read ack of the same port, writes leave it alone
`timescale 1ns/1ns

module mau_line_assembler #(
	parameter int LINE_WORDS = 4
) (
	input  logic                                         wb_clk_i,
	input  logic                                         rst_n,
	input  logic                                         wb_ack_i,
	input  logic [mau_pkg::MAU_DATA_WIDTH-1:0]           wb_dat_i,
	mau_tag_if.collect                                   tag,
	mau_cnt_if.ctrl                                      cnt,
	output logic                                         l1i_req_ack_o,
	output logic [LINE_WORDS*mau_pkg::MAU_DATA_WIDTH-1:0] l1i_ack_data_o,
	output logic                                         l1d_req_ack_o,
	output logic [LINE_WORDS*mau_pkg::MAU_DATA_WIDTH-1:0] l1d_ack_data_o,
	output logic                                         l1d_ack_nc_o,
	output logic                                         l1d_ack_we_o
);

	localparam int DW = mau_pkg::MAU_DATA_WIDTH;

	mau_pkg::mau_tag_t                    head;
	logic                                 collecting_q;
	logic                                 ack_last;
	logic [mau_pkg::MAU_CNT_WIDTH-1:0]    wr_idx;

	assign head = tag.pop_tag;

	// First ack of a request uses the head tag directly
	assign ack_last = collecting_q ? cnt.last : (head.last_idx == '0);
	assign wr_idx   = collecting_q ? cnt.idx : '0;

	assign cnt.load  = wb_ack_i & ~collecting_q;
	assign cnt.limit = head.last_idx;
	assign cnt.step  = wb_ack_i & ~ack_last;
	assign tag.pop   = wb_ack_i & ack_last;

	// ------------------------------
	// Port acks
	// ------------------------------

	always_ff @(posedge wb_clk_i or negedge rst_n) begin
		if (!rst_n) begin
			collecting_q  <= 1'b0;
			l1i_req_ack_o <= 1'b0;
			l1d_req_ack_o <= 1'b0;
			l1d_ack_nc_o  <= 1'b0;
			l1d_ack_we_o  <= 1'b0;
		end else begin
			if (wb_ack_i)
				collecting_q <= ~ack_last;
			l1i_req_ack_o <= tag.pop & (head.src == mau_pkg::SRC_I);
			l1d_req_ack_o <= tag.pop & (head.src == mau_pkg::SRC_D);
			if (tag.pop && head.src == mau_pkg::SRC_D) begin
				l1d_ack_nc_o <= head.nc;
				l1d_ack_we_o <= head.we;
			end
		end
	end

	// ------------------------------
	// Line data
	// ------------------------------

	always_ff @(posedge wb_clk_i) begin
		if (wb_ack_i && !head.we) begin
			if (head.src == mau_pkg::SRC_D)
				l1d_ack_data_o[wr_idx*DW +: DW] <= wb_dat_i;
			else
				l1i_ack_data_o[wr_idx*DW +: DW] <= wb_dat_i;
		end
	end

	// Every bus ack must match a request issued earlier
	a_ack_has_tag: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
		wb_ack_i |-> !tag.empty);

endmodule

// File: l1_mau.sv
// L1 memory access unit, top level
// Instruction line fills and data read, write and uncached requests become
// Wishbone B4 pipelined bursts, one word per beat
// Cached read addresses must be line aligned
// No err, rty, lock or tag signals on the bus
`timescale 1ns/1ns

module l1_mau #(
	parameter int LINE_WORDS = 4,
	parameter int TAG_DEPTH  = 2
) (
	input  logic                                          wb_clk_i,
	input  logic                                          rst_n,

	// Instruction cache port
	input  logic                                          l1i_req_val_i,
	input  logic [mau_pkg::MAU_ADDR_WIDTH-1:0]            l1i_req_addr_i,
	output logic                                          l1i_req_ack_o,
	output logic [LINE_WORDS*mau_pkg::MAU_DATA_WIDTH-1:0] l1i_ack_data_o,

	// Data cache port
	input  logic                                          l1d_req_val_i,
	input  logic                                          l1d_req_nc_i,
	input  logic                                          l1d_req_we_i,
	input  logic [mau_pkg::MAU_ADDR_WIDTH-1:0]            l1d_req_addr_i,
	input  logic [mau_pkg::MAU_DATA_WIDTH-1:0]            l1d_req_wdata_i,
	input  logic [mau_pkg::MAU_BE_WIDTH-1:0]              l1d_req_be_i,
	output logic                                          l1d_req_ack_o,
	output logic [LINE_WORDS*mau_pkg::MAU_DATA_WIDTH-1:0] l1d_ack_data_o,
	output logic                                          l1d_ack_nc_o,
	output logic                                          l1d_ack_we_o,

	// Wishbone master
	input  logic                                          wb_ack_i,
	input  logic [mau_pkg::MAU_DATA_WIDTH-1:0]            wb_dat_i,
	input  logic                                          wb_stall_i,
	output logic [mau_pkg::MAU_ADDR_WIDTH-1:0]            wb_adr_o,
	output logic [mau_pkg::MAU_DATA_WIDTH-1:0]            wb_dat_o,
	output logic [mau_pkg::MAU_BE_WIDTH-1:0]              wb_sel_o,
	output logic                                          wb_we_o,
	output logic                                          wb_stb_o,
	output logic                                          wb_cyc_o
);

	mau_tag_if tag_if ();
	mau_cnt_if issue_cnt_if ();
	mau_cnt_if ack_cnt_if ();

	mau_issue_fsm #(
		.LINE_WORDS (LINE_WORDS)
	) u_issue_fsm (
		.wb_clk_i        (wb_clk_i),
		.rst_n           (rst_n),
		.l1i_req_val_i   (l1i_req_val_i),
		.l1i_req_addr_i  (l1i_req_addr_i),
		.l1d_req_val_i   (l1d_req_val_i),
		.l1d_req_nc_i    (l1d_req_nc_i),
		.l1d_req_we_i    (l1d_req_we_i),
		.l1d_req_addr_i  (l1d_req_addr_i),
		.l1d_req_wdata_i (l1d_req_wdata_i),
		.l1d_req_be_i    (l1d_req_be_i),
		.l1i_req_ack_i   (l1i_req_ack_o),
		.l1d_req_ack_i   (l1d_req_ack_o),
		.wb_stall_i      (wb_stall_i),
		.wb_adr_o        (wb_adr_o),
		.wb_dat_o        (wb_dat_o),
		.wb_sel_o        (wb_sel_o),
		.wb_we_o         (wb_we_o),
		.wb_stb_o        (wb_stb_o),
		.wb_cyc_o        (wb_cyc_o),
		.tag             (tag_if.issue),
		.cnt             (issue_cnt_if.ctrl)
	);

	mau_beat_counter issue_cnt (
		.wb_clk_i (wb_clk_i),
		.rst_n    (rst_n),
		.cnt      (issue_cnt_if.cnt)
	);

	mau_beat_counter ack_cnt (
		.wb_clk_i (wb_clk_i),
		.rst_n    (rst_n),
		.cnt      (ack_cnt_if.cnt)
	);

	mau_tag_queue #(
		.TAG_DEPTH (TAG_DEPTH)
	) u_tag_queue (
		.wb_clk_i (wb_clk_i),
		.rst_n    (rst_n),
		.q        (tag_if.queue)
	);

	mau_line_assembler #(
		.LINE_WORDS (LINE_WORDS)
	) u_line_assembler (
		.wb_clk_i       (wb_clk_i),
		.rst_n          (rst_n),
		.wb_ack_i       (wb_ack_i),
		.wb_dat_i       (wb_dat_i),
		.tag            (tag_if.collect),
		.cnt            (ack_cnt_if.ctrl),
		.l1i_req_ack_o  (l1i_req_ack_o),
		.l1i_ack_data_o (l1i_ack_data_o),
		.l1d_req_ack_o  (l1d_req_ack_o),
		.l1d_ack_data_o (l1d_ack_data_o),
		.l1d_ack_nc_o   (l1d_ack_nc_o),
		.l1d_ack_we_o   (l1d_ack_we_o)
	);

endmodule

// File: tb_wb_mem.sv
// Wishbone B4 pipelined slave memory for the testbench
// 256 words, the word index is address bits 9:2 and higher bits are ignored
// Random stall, ack delay of 0 to 3 cycles, acks stay in request order
// All outputs change on the falling clock edge
`timescale 1ns/1ns

module tb_wb_mem (
	input  logic        wb_clk_i,
	input  logic        rst_n,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	input  logic        wb_we_i,
	input  logic [31:0] wb_adr_i,
	input  logic [31:0] wb_dat_i,
	input  logic [3:0]  wb_sel_i,
	output logic        wb_stall_o,
	output logic        wb_ack_o,
	output logic [31:0] wb_dat_o
);

	logic [31:0] mem_q [256];
	logic [31:0] rdata_q [$];
	int          due_q [$];
	int          cyc_n;
	int          last_due;
	int          due;
	logic [7:0]  widx;

	// Every byte of the word depends on the full word address
	function automatic logic [31:0] fill_word(input logic [7:0] a);
		return {a ^ 8'hc3, ~a, a, a + 8'h5b};
	endfunction

	initial begin
		wb_stall_o = 1'b0;
		wb_ack_o   = 1'b0;
		wb_dat_o   = '0;
		cyc_n      = 0;
		last_due   = 0;
		for (int i = 0; i < 256; i++)
			mem_q[i] = fill_word(8'(i));
	end

	always @(negedge wb_clk_i) begin
		if (!rst_n) begin
			rdata_q.delete();
			due_q.delete();
			wb_stall_o = 1'b0;
			wb_ack_o   = 1'b0;
			cyc_n      = 0;
			last_due   = 0;
		end else begin
			cyc_n++;
			// Return the oldest beat once its delay has run out
			if (due_q.size() != 0 && due_q[0] <= cyc_n) begin
				wb_ack_o = 1'b1;
				wb_dat_o = rdata_q.pop_front();
				due      = due_q.pop_front();
			end else begin
				wb_ack_o = 1'b0;
			end
			wb_stall_o = ($urandom_range(3) == 0);
			// Beat is taken at the next rising edge
			if (wb_cyc_i && wb_stb_i && !wb_stall_o) begin
				widx = wb_adr_i[9:2];
				if (wb_we_i) begin
					for (int b = 0; b < 4; b++)
						if (wb_sel_i[b])
							mem_q[widx][b*8 +: 8] = wb_dat_i[b*8 +: 8];
				end
				rdata_q.push_back(mem_q[widx]);
				due = cyc_n + 1 + $urandom_range(3);
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				due_q.push_back(due);
			end
		end
	end

endmodule

// File: tb_l1_mau.sv
// Testbench for the L1 memory access unit
// Instruction fills use memory words 0 to 127 and data requests words 128 to 255,
// so the bus order between the two ports never changes an expected result
`timescale 1ns/1ns

module tb_l1_mau;

	localparam int LINE_WORDS   = 4;
	localparam int TAG_DEPTH    = 2;
	localparam int LINE_BITS    = LINE_WORDS * 32;
	localparam int NUM_REQ      = 70;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_CYCLES   = 200 * NUM_REQ + RESET_CYCLES;

	logic                 wb_clk_i;
	logic                 rst_n;
	logic                 l1i_req_val_i;
	logic [31:0]          l1i_req_addr_i;
	logic                 l1i_req_ack_o;
	logic [LINE_BITS-1:0] l1i_ack_data_o;
	logic                 l1d_req_val_i;
	logic                 l1d_req_nc_i;
	logic                 l1d_req_we_i;
	logic [31:0]          l1d_req_addr_i;
	logic [31:0]          l1d_req_wdata_i;
	logic [3:0]           l1d_req_be_i;
	logic                 l1d_req_ack_o;
	logic [LINE_BITS-1:0] l1d_ack_data_o;
	logic                 l1d_ack_nc_o;
	logic                 l1d_ack_we_o;
	logic                 wb_ack_i;
	logic [31:0]          wb_dat_i;
	logic                 wb_stall_i;
	logic [31:0]          wb_adr_o;
	logic [31:0]          wb_dat_o;
	logic [3:0]           wb_sel_o;
	logic                 wb_we_o;
	logic                 wb_stb_o;
	logic                 wb_cyc_o;

	// Expected state shared by the drivers and the compare process
	logic [31:0]          shadow [256];
	logic [LINE_BITS-1:0] exp_i;
	logic [LINE_BITS-1:0] exp_d;
	logic                 exp_d_nc;
	logic                 exp_d_we;
	string                name_i;
	string                name_d;
	logic                 pend_i;
	logic                 pend_d;
	int                   cycles = 0;
	int                   ack_cyc_i;
	int                   ack_cyc_d;
	int                   kind;
	logic [31:0]          rnd_addr;
	logic [31:0]          rnd_data;
	logic [3:0]           rnd_be;

	initial wb_clk_i = 1'b0;
	always #20 wb_clk_i = ~wb_clk_i;

	l1_mau #(
		.LINE_WORDS (LINE_WORDS),
		.TAG_DEPTH  (TAG_DEPTH)
	) uut (
		.wb_clk_i        (wb_clk_i),
		.rst_n           (rst_n),
		.l1i_req_val_i   (l1i_req_val_i),
		.l1i_req_addr_i  (l1i_req_addr_i),
		.l1i_req_ack_o   (l1i_req_ack_o),
		.l1i_ack_data_o  (l1i_ack_data_o),
		.l1d_req_val_i   (l1d_req_val_i),
		.l1d_req_nc_i    (l1d_req_nc_i),
		.l1d_req_we_i    (l1d_req_we_i),
		.l1d_req_addr_i  (l1d_req_addr_i),
		.l1d_req_wdata_i (l1d_req_wdata_i),
		.l1d_req_be_i    (l1d_req_be_i),
		.l1d_req_ack_o   (l1d_req_ack_o),
		.l1d_ack_data_o  (l1d_ack_data_o),
		.l1d_ack_nc_o    (l1d_ack_nc_o),
		.l1d_ack_we_o    (l1d_ack_we_o),
		.wb_ack_i        (wb_ack_i),
		.wb_dat_i        (wb_dat_i),
		.wb_stall_i      (wb_stall_i),
		.wb_adr_o        (wb_adr_o),
		.wb_dat_o        (wb_dat_o),
		.wb_sel_o        (wb_sel_o),
		.wb_we_o         (wb_we_o),
		.wb_stb_o        (wb_stb_o),
		.wb_cyc_o        (wb_cyc_o)
	);

	tb_wb_mem u_mem (
		.wb_clk_i   (wb_clk_i),
		.rst_n      (rst_n),
		.wb_cyc_i   (wb_cyc_o),
		.wb_stb_i   (wb_stb_o),
		.wb_we_i    (wb_we_o),
		.wb_adr_i   (wb_adr_o),
		.wb_dat_i   (wb_dat_o),
		.wb_sel_i   (wb_sel_o),
		.wb_stall_o (wb_stall_i),
		.wb_ack_o   (wb_ack_i),
		.wb_dat_o   (wb_dat_i)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string test, input logic [LINE_BITS-1:0] expv,
	                               input logic [LINE_BITS-1:0] actv);
		stop_run($sformatf("** Error [%s] expected %h, actual %h", test, expv, actv));
	endtask

	// ------------------------------
	// Reference model
	// ------------------------------

	// Full line, word 0 of an uncached read, or the merged word of a write
	function automatic logic [LINE_BITS-1:0] ref_result(input logic [31:0] addr,
		input logic nc, input logic we, input logic [31:0] wdata, input logic [3:0] be);
		logic [LINE_BITS-1:0] line;
		logic [7:0]           w;
		line = '0;
		w    = addr[9:2];
		if (we) begin
			for (int b = 0; b < 4; b++)
				line[b*8 +: 8] = be[b] ? wdata[b*8 +: 8] : shadow[w][b*8 +: 8];
		end else if (nc) begin
			line[31:0] = shadow[w];
		end else begin
			for (int j = 0; j < LINE_WORDS; j++)
				line[j*32 +: 32] = shadow[w + j];
		end
		return line;
	endfunction

	task automatic fetch_line(input string name, input logic [31:0] addr);
		@(negedge wb_clk_i);
		exp_i          = ref_result(addr, 1'b0, 1'b0, '0, '0);
		name_i         = name;
		pend_i         = 1'b1;
		l1i_req_addr_i = addr;
		l1i_req_val_i  = 1'b1;
		@(negedge wb_clk_i);
		while (!l1i_req_ack_o)
			@(negedge wb_clk_i);
		l1i_req_val_i = 1'b0;
	endtask

	task automatic data_access(input string name, input logic nc, input logic we,
		input logic [31:0] addr, input logic [31:0] wdata, input logic [3:0] be);
		@(negedge wb_clk_i);
		exp_d    = ref_result(addr, nc, we, wdata, be);
		exp_d_nc = nc;
		exp_d_we = we;
		name_d   = name;
		pend_d   = 1'b1;
		// Writes are single ordered beats, so memory takes them in this order
		if (we)
			shadow[addr[9:2]] = exp_d[31:0];
		l1d_req_nc_i    = nc;
		l1d_req_we_i    = we;
		l1d_req_addr_i  = addr;
		l1d_req_wdata_i = wdata;
		l1d_req_be_i    = be;
		l1d_req_val_i   = 1'b1;
		@(negedge wb_clk_i);
		while (!l1d_req_ack_o)
			@(negedge wb_clk_i);
		l1d_req_val_i = 1'b0;
	endtask

	// ------------------------------
	// Compare process
	// ------------------------------

	always @(negedge wb_clk_i) begin
		if (rst_n && l1i_req_ack_o) begin
			assert (pend_i) else stop_run("Instruction port ack with no request outstanding");
			assert (l1i_ack_data_o == exp_i) else report_mismatch(name_i, exp_i, l1i_ack_data_o);
			pend_i    = 1'b0;
			ack_cyc_i = cycles;
		end
		if (rst_n && l1d_req_ack_o) begin
			assert (pend_d) else stop_run("Data port ack with no request outstanding");
			assert ({l1d_ack_nc_o, l1d_ack_we_o} == {exp_d_nc, exp_d_we})
				else report_mismatch(name_d, {exp_d_nc, exp_d_we}, {l1d_ack_nc_o, l1d_ack_we_o});
			if (exp_d_nc && !exp_d_we) begin
				assert (l1d_ack_data_o[31:0] == exp_d[31:0])
					else report_mismatch(name_d, exp_d[31:0], l1d_ack_data_o[31:0]);
			end else if (!exp_d_we) begin
				assert (l1d_ack_data_o == exp_d) else report_mismatch(name_d, exp_d, l1d_ack_data_o);
			end
			pend_d    = 1'b0;
			ack_cyc_d = cycles;
		end
	end

	// Hang guard
	always @(posedge wb_clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
			stop_run($sformatf("Timeout after %0d cycles, the DUT stopped answering", cycles));
	end

	initial begin
		void'($urandom(32'h6e5e));
		rst_n           = 1'b0;
		l1i_req_val_i   = 1'b0;
		l1i_req_addr_i  = '0;
		l1d_req_val_i   = 1'b0;
		l1d_req_nc_i    = 1'b0;
		l1d_req_we_i    = 1'b0;
		l1d_req_addr_i  = '0;
		l1d_req_wdata_i = '0;
		l1d_req_be_i    = '0;
		pend_i          = 1'b0;
		pend_d          = 1'b0;
		repeat (RESET_CYCLES) @(negedge wb_clk_i);
		rst_n = 1'b1;
		for (int i = 0; i < 256; i++)
			shadow[i] = u_mem.mem_q[i];

		repeat (3) begin
			@(negedge wb_clk_i);
			assert (!wb_cyc_o && !wb_stb_o && !l1i_req_ack_o && !l1d_req_ack_o)
				else stop_run("Bus strobe, cycle or a port ack active after reset");
		end

		fetch_line("ifetch_a", 32'h0000_0040);
		fetch_line("ifetch_b", 32'h0000_01f0);
		data_access("dread", 1'b0, 1'b0, 32'h0000_0300, '0, '0);
		data_access("dread_nc", 1'b1, 1'b0, 32'h0000_030c, '0, '0);
		data_access("dwrite_a", 1'b0, 1'b1, 32'h0000_0224, 32'hdead_beef, 4'b0101);
		data_access("merge_a", 1'b1, 1'b0, 32'h0000_0224, '0, '0);
		data_access("dwrite_b", 1'b0, 1'b1, 32'h0000_0380, $urandom, 4'($urandom_range(15)));
		data_access("merge_b", 1'b1, 1'b0, 32'h0000_0380, '0, '0);

		// Same cycle request on both ports, data wins arbitration
		fork
			fetch_line("both_i", 32'h0000_0100);
			data_access("both_d", 1'b0, 1'b0, 32'h0000_0240, '0, '0);
		join
		@(negedge wb_clk_i);
		assert (ack_cyc_d <= ack_cyc_i) else stop_run("Data ack came after the instruction ack");

		fork
			begin : rand_i
				for (int n = 0; n < 30; n++) begin
					repeat ($urandom_range(2)) @(negedge wb_clk_i);
					fetch_line("rand_ifetch", 32'($urandom_range(31)) << 4);
				end
			end
			begin : rand_d
				for (int n = 0; n < 30; n++) begin
					repeat ($urandom_range(2)) @(negedge wb_clk_i);
					kind     = $urandom_range(2);
					rnd_data = $urandom;
					rnd_be   = 4'($urandom_range(15));
					if (kind == 0) begin
						rnd_addr = 32'h200 + (32'($urandom_range(31)) << 4);
						data_access("rand_dread", 1'b0, 1'b0, rnd_addr, '0, '0);
					end else begin
						rnd_addr = 32'h200 + (32'($urandom_range(127)) << 2);
						data_access(kind == 1 ? "rand_dunc" : "rand_dwrite", kind == 1,
						            kind == 2, rnd_addr, rnd_data, rnd_be);
					end
				end
			end
		join
		// Bus must be released once the last port ack has gone out
		@(negedge wb_clk_i);
		assert (!wb_cyc_o && !wb_stb_o) else stop_run("Bus cycle still active after the last ack");

		$display("Verification passed");
		$finish;
	end

endmodule

// File: vlog.f
mau_pkg.sv
mau_if.sv
mau_beat_counter.sv
mau_tag_queue.sv
mau_issue_fsm.sv
mau_line_assembler.sv
l1_mau.sv
tb_wb_mem.sv
tb_l1_mau.sv
